// ==== project.f ====
+incdir+test
src/opb_pkg.sv
src/opb_reg_port.sv
src/sys_block.sv
src/irq_ctrl.sv
src/opb_sys_top.sv
test/tb_opb_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_opb_sys -f project.f -o tb_opb_sys > build.log 2>&1 \
  && ./obj_dir/tb_opb_sys > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }

cat sim.log
grep -q "All tests passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== src/irq_ctrl.sv ====
`default_nettype none

module irq_ctrl #(
  parameter logic [0:31] BASEADDR = 32'h0000_0100,
  parameter logic [0:31] HIGHADDR = 32'h0000_01FF
) (
  input  logic                           OPB_Clk,
  input  logic                           reset,
  input  opb_pkg::opb_req_t              req,
  output opb_pkg::opb_rsp_t              rsp,
  input  logic [opb_pkg::IRQ_LINES-1:0]  app_irq,
  output logic                           irq_n
);

  localparam int N   = opb_pkg::IRQ_LINES;
  localparam int LSB = opb_pkg::DATA_W - N; // First data bit used by the lines.

  opb_pkg::reg_acc_t          acc;
  logic [0:opb_pkg::DATA_W-1] rdata;
  logic [0:opb_pkg::DATA_W-1] be_mask;
  logic [0:opb_pkg::DATA_W-1] wmasked;

  logic [N-1:0] raw_q;      // Synchronized lines.
  logic [N-1:0] raw_d;      // One cycle older, for edge detection.
  logic [N-1:0] rise;
  logic [N-1:0] status;
  logic [N-1:0] enable;
  logic [N-1:0] pending;
  logic [N-1:0] lane_lines;
  logic [N-1:0] wr_lines;
  logic         wr_status;
  logic         wr_enable;

  opb_reg_port #(
    .BASEADDR (BASEADDR),
    .HIGHADDR (HIGHADDR)
  ) u_opb_reg_port (
    .OPB_Clk (OPB_Clk),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .acc     (acc),
    .rdata   (rdata)
  );

  // Expand the byte enables to a bit mask.
  always_comb begin
    for (int i = 0; i < opb_pkg::BE_W; i++) begin
      be_mask[8*i +: 8] = {8{acc.be[i]}};
    end
  end

  assign wmasked    = acc.wdata & be_mask;
  assign lane_lines = be_mask[LSB:opb_pkg::DATA_W-1]; // Line 0 sits at bit 31.
  assign wr_lines   = wmasked[LSB:opb_pkg::DATA_W-1];

  assign wr_status = acc.valid && acc.write && (acc.reg_index == 3'd0);
  assign wr_enable = acc.valid && acc.write && (acc.reg_index == 3'd1);

  assign rise    = raw_q & ~raw_d;
  assign pending = status & enable;

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      raw_q <= '0;
      raw_d <= '0;
    end else begin
      raw_q <= app_irq;
      raw_d <= raw_q;
    end
  end

  // Sticky status with write-one-to-clear. A fresh edge beats the clear.
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      status <= '0;
    end else if (wr_status) begin
      status <= (status & ~wr_lines) | rise;
    end else begin
      status <= status | rise;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      enable <= '0;
    end else if (wr_enable) begin
      enable <= (enable & ~lane_lines) | wr_lines;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      irq_n <= 1'b1;
    end else begin
      irq_n <= ~|pending; // Active low.
    end
  end

  always_comb begin
    case (acc.reg_index)
      3'd0:    rdata = {{LSB{1'b0}}, status};
      3'd1:    rdata = {{LSB{1'b0}}, enable};
      3'd2:    rdata = {{LSB{1'b0}}, pending};
      3'd3:    rdata = {{LSB{1'b0}}, raw_q};
      default: rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/opb_pkg.sv ====
`default_nettype none

package opb_pkg;

  // Bus geometry. OPB numbers bits big-endian, so bit 0 is the MSB.
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // Word offset inside one slave window.
  localparam int REG_INDEX_W = 3;

  // Application interrupt lines seen by the interrupt controller.
  localparam int IRQ_LINES = 16;

  // Master to slave. 71 bits.
  typedef struct packed {
    logic [0:DATA_W-1] abus;     // Address bus.
    logic [0:BE_W-1]   be;       // Byte enables, lane 0 is bits 0..7.
    logic [0:DATA_W-1] dbus;     // Write data.
    logic              rnw;      // Read not write.
    logic              select;   // Transfer in progress.
    logic              seq_addr; // Sequential address hint.
  } opb_req_t;

  // Slave to master. 36 bits.
  // All-zero while the slave does not acknowledge.
  typedef struct packed {
    logic [0:DATA_W-1] dbus;     // Read data.
    logic              xfer_ack; // Transfer acknowledge.
    logic              err_ack;  // Error acknowledge.
    logic              retry;    // Retry request.
    logic              tout_sup; // Timeout suppression.
  } opb_rsp_t;

  // One decoded register access from the bus front end. 41 bits.
  typedef struct packed {
    logic                   valid;     // High in the acknowledge cycle.
    logic                   write;     // Write access.
    logic [REG_INDEX_W-1:0] reg_index; // Word offset in the window.
    logic [0:BE_W-1]        be;        // Byte enables.
    logic [0:DATA_W-1]      wdata;     // Write data.
  } reg_acc_t;

endpackage

`default_nettype wire

// ==== src/opb_reg_port.sv ====
`default_nettype none

module opb_reg_port #(
  parameter logic [0:31] BASEADDR = 32'h0000_0000,
  parameter logic [0:31] HIGHADDR = 32'h0000_00FF
) (
  input  logic                          OPB_Clk,
  input  logic                          reset,
  input  opb_pkg::opb_req_t             req,
  output opb_pkg::opb_rsp_t             rsp,
  output opb_pkg::reg_acc_t             acc,
  input  logic [0:opb_pkg::DATA_W-1]    rdata
);

  // Window size minus one. A single unsigned compare on the offset covers
  // both bounds, since addresses below the base wrap to large offsets.
  localparam logic [0:31] SPAN = HIGHADDR - BASEADDR;

  logic [0:31] offset;
  logic        hit;
  logic        xfer_ack;

  logic                            wr_q;
  logic [opb_pkg::REG_INDEX_W-1:0] idx_q;
  logic [0:opb_pkg::BE_W-1]        be_q;
  logic [0:opb_pkg::DATA_W-1]      wdata_q;

  assign offset = req.abus - BASEADDR;
  assign hit    = req.select && (offset <= SPAN);

  // One-cycle acknowledge, never two in a row.
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      xfer_ack <= 1'b0;
    end else begin
      xfer_ack <= hit && !xfer_ack;
    end
  end

  // Access payload. The master holds its request until the acknowledge,
  // so sampling every cycle gives the right values in the ack cycle.
  always_ff @(posedge OPB_Clk) begin
    wr_q    <= !req.rnw;
    idx_q   <= offset[30-opb_pkg::REG_INDEX_W:29]; // Word offset.
    be_q    <= req.be;
    wdata_q <= req.dbus;
  end

  always_comb begin
    acc.valid     = xfer_ack;
    acc.write     = wr_q;
    acc.reg_index = idx_q;
    acc.be        = be_q;
    acc.wdata     = wdata_q;
  end

  always_comb begin
    rsp          = '0;
    rsp.xfer_ack = xfer_ack;
    if (xfer_ack && !wr_q) begin
      rsp.dbus = rdata; // Data only in the ack cycle of a read.
    end
  end

endmodule

`default_nettype wire

// ==== src/opb_sys_top.sv ====
`default_nettype none

module opb_sys_top #(
  parameter logic [15:0] BOARD_ID     = 16'h0000,
  parameter logic [15:0] REV_MAJOR    = 16'h0000,
  parameter logic [15:0] REV_MINOR    = 16'h0000,
  parameter logic [15:0] REV_RCS      = 16'h0000,
  parameter logic        RCS_UPTODATE = 1'b0,
  parameter logic [0:31] SYS_BASEADDR = 32'h0000_0000,
  parameter logic [0:31] SYS_HIGHADDR = 32'h0000_00FF,
  parameter logic [0:31] IRQ_BASEADDR = 32'h0000_0100,
  parameter logic [0:31] IRQ_HIGHADDR = 32'h0000_01FF
) (
  input  logic                          OPB_Clk,
  input  logic                          reset,
  input  opb_pkg::opb_req_t             opb_req,
  output opb_pkg::opb_rsp_t             opb_rsp,
  output logic                          soft_reset,
  output logic                          irq_n,
  input  logic [opb_pkg::IRQ_LINES-1:0] app_irq
);

  opb_pkg::opb_rsp_t sys_rsp;
  opb_pkg::opb_rsp_t irq_rsp;

  sys_block #(
    .BASEADDR     (SYS_BASEADDR),
    .HIGHADDR     (SYS_HIGHADDR),
    .BOARD_ID     (BOARD_ID),
    .REV_MAJOR    (REV_MAJOR),
    .REV_MINOR    (REV_MINOR),
    .REV_RCS      (REV_RCS),
    .RCS_UPTODATE (RCS_UPTODATE)
  ) u_sys_block (
    .OPB_Clk    (OPB_Clk),
    .reset      (reset),
    .req        (opb_req),
    .rsp        (sys_rsp),
    .soft_reset (soft_reset)
  );

  irq_ctrl #(
    .BASEADDR (IRQ_BASEADDR),
    .HIGHADDR (IRQ_HIGHADDR)
  ) u_irq_ctrl (
    .OPB_Clk (OPB_Clk),
    .reset   (reset),
    .req     (opb_req),
    .rsp     (irq_rsp),
    .app_irq (app_irq),
    .irq_n   (irq_n)
  );

  // Idle slaves drive zero, so OR-ing the responses is the bus mux.
  assign opb_rsp.dbus     = sys_rsp.dbus     | irq_rsp.dbus;
  assign opb_rsp.xfer_ack = sys_rsp.xfer_ack | irq_rsp.xfer_ack;
  assign opb_rsp.err_ack  = sys_rsp.err_ack  | irq_rsp.err_ack;
  assign opb_rsp.retry    = sys_rsp.retry    | irq_rsp.retry;
  assign opb_rsp.tout_sup = sys_rsp.tout_sup | irq_rsp.tout_sup;

endmodule

`default_nettype wire

// ==== src/sys_block.sv ====
`default_nettype none

module sys_block #(
  parameter logic [0:31] BASEADDR     = 32'h0000_0000,
  parameter logic [0:31] HIGHADDR     = 32'h0000_00FF,
  parameter logic [15:0] BOARD_ID     = 16'h0000,
  parameter logic [15:0] REV_MAJOR    = 16'h0000,
  parameter logic [15:0] REV_MINOR    = 16'h0000,
  parameter logic [15:0] REV_RCS      = 16'h0000,
  parameter logic        RCS_UPTODATE = 1'b0
) (
  input  logic              OPB_Clk,
  input  logic              reset,
  input  opb_pkg::opb_req_t req,
  output opb_pkg::opb_rsp_t rsp,
  output logic              soft_reset
);

  localparam logic [0:31] SCRATCH_INIT = 32'hB00B_EEE5;

  opb_pkg::reg_acc_t          acc;
  logic [0:opb_pkg::DATA_W-1] rdata;
  logic [0:opb_pkg::DATA_W-1] scratch;
  logic                       wr_scratch;

  opb_reg_port #(
    .BASEADDR (BASEADDR),
    .HIGHADDR (HIGHADDR)
  ) u_opb_reg_port (
    .OPB_Clk (OPB_Clk),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .acc     (acc),
    .rdata   (rdata)
  );

  // Pulse lasts exactly the acknowledge cycle of the write.
  assign soft_reset = acc.valid && acc.write && (acc.reg_index == 3'd2) &&
                      acc.be[3] && acc.wdata[31];

  assign wr_scratch = acc.valid && acc.write && (acc.reg_index == 3'd3);

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      scratch <= SCRATCH_INIT;
    end else if (wr_scratch) begin
      for (int i = 0; i < opb_pkg::BE_W; i++) begin
        if (acc.be[i]) begin
          scratch[8*i +: 8] <= acc.wdata[8*i +: 8]; // Lane 0 is bits 0..7.
        end
      end
    end
  end

  // Read mux, upper half first.
  always_comb begin
    rdata = '0;
    case (acc.reg_index)
      3'd0: begin
        rdata[0:15]  = BOARD_ID;
        rdata[16:31] = REV_MAJOR;
      end
      3'd1: begin
        rdata[0:15]  = REV_MINOR;
        rdata[16:31] = REV_RCS;
      end
      3'd2: begin
        rdata[15] = RCS_UPTODATE;
        rdata[31] = soft_reset;
      end
      3'd3: begin
        rdata = scratch;
      end
      default: begin
        rdata = '0; // Unused words read as zero.
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  task automatic check_word(input string name,
                            input logic [0:opb_pkg::DATA_W-1] got,
                            input logic [0:opb_pkg::DATA_W-1] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // One OPB transfer. Starts and ends on a falling edge.
  task automatic bus_transfer(input  logic [0:opb_pkg::DATA_W-1] addr,
                              input  logic                       rnw,
                              input  logic [0:opb_pkg::BE_W-1]   be,
                              input  logic [0:opb_pkg::DATA_W-1] wdata,
                              output logic [0:opb_pkg::DATA_W-1] rdata);
    int   waited;
    logic acked;
    waited            = 0;
    acked             = 1'b0;
    rdata             = '0;
    soft_reset_at_ack = 1'b0;
    req.abus     = addr;
    req.be       = be;
    req.dbus     = wdata;
    req.rnw      = rnw;
    req.select   = 1'b1;
    req.seq_addr = 1'b0;
    while (!acked && waited < ACK_WAIT) begin
      @(negedge OPB_Clk);
      waited++;
      if (rsp.xfer_ack) begin
        acked             = 1'b1;
        rdata             = rsp.dbus;
        soft_reset_at_ack = soft_reset;
        check_bit("err_ack", rsp.err_ack, 1'b0);
        check_bit("retry", rsp.retry, 1'b0);
        check_bit("tout_sup", rsp.tout_sup, 1'b0);
        if (!rnw) begin
          check_word("dbus on write", rsp.dbus, '0);
        end
      end
    end
    if (!acked) begin
      errors++;
      $display("No transfer acknowledge for address %h within %0d cycles", addr, ACK_WAIT);
    end
    // Select is still high here, so a second acknowledge would show up.
    @(negedge OPB_Clk);
    if (acked) begin
      check_bit("xfer_ack after ack cycle", rsp.xfer_ack, 1'b0);
      check_word("dbus after ack cycle", rsp.dbus, '0);
    end
    req = '0; // Master drops select one cycle after the acknowledge.
  endtask

  task automatic opb_write(input logic [0:opb_pkg::DATA_W-1] addr,
                           input logic [0:opb_pkg::BE_W-1]   be,
                           input logic [0:opb_pkg::DATA_W-1] data);
    logic [0:opb_pkg::DATA_W-1] unused;
    bus_transfer(addr, 1'b0, be, data, unused);
  endtask

  task automatic opb_read(input  logic [0:opb_pkg::DATA_W-1] addr,
                          output logic [0:opb_pkg::DATA_W-1] data);
    bus_transfer(addr, 1'b1, 4'hF, '0, data);
  endtask

`endif

// ==== test/tb_opb_sys.sv ====
`default_nettype none

module tb_opb_sys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [0:31] SYS_ID      = 32'h0000_0000;
  localparam logic [0:31] SYS_REV     = 32'h0000_0004;
  localparam logic [0:31] SYS_CTRL    = 32'h0000_0008;
  localparam logic [0:31] SYS_SCRATCH = 32'h0000_000C;
  localparam logic [0:31] IRQ_STATUS  = 32'h0000_0100;
  localparam logic [0:31] IRQ_ENABLE  = 32'h0000_0104;
  localparam logic [0:31] IRQ_PENDING = 32'h0000_0108;
  localparam logic [0:31] UNMAPPED    = 32'h0000_0400;

  localparam int SCRATCH_WRITES = 20;
  localparam int IRQ_ROUNDS     = 3;
  localparam int ACK_WAIT       = 16;
  // Identity, scratch, soft reset, interrupt rounds, unmapped probe.
  localparam int NUM_XFERS = 3 + (1 + 2 * SCRATCH_WRITES) + 2 + 6 * IRQ_ROUNDS + 1;

  logic                          OPB_Clk;
  logic                          reset;
  opb_pkg::opb_req_t             req;
  opb_pkg::opb_rsp_t             rsp;
  logic                          soft_reset;
  logic                          irq_n;
  logic [opb_pkg::IRQ_LINES-1:0] app_irq;

  int   errors;
  int   checks;
  logic soft_reset_at_ack;

  opb_sys_top #(
    .BOARD_ID     (16'h0A55),
    .REV_MAJOR    (16'd2),
    .REV_MINOR    (16'd7),
    .REV_RCS      (16'h1234),
    .RCS_UPTODATE (1'b1)
  ) u_opb_sys_top (
    .OPB_Clk    (OPB_Clk),
    .reset      (reset),
    .opb_req    (req),
    .opb_rsp    (rsp),
    .soft_reset (soft_reset),
    .irq_n      (irq_n),
    .app_irq    (app_irq)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  initial begin
    #((NUM_XFERS * 20 + 2000) * 10);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(21));
    errors            = 0;
    checks            = 0;
    soft_reset_at_ack = 1'b0;
    reset             = 1'b1;
    req               = '0;
    app_irq           = '0;
    repeat (16) @(negedge OPB_Clk);
    reset = 1'b0;
    @(negedge OPB_Clk);
    check_bit("xfer_ack", rsp.xfer_ack, 1'b0);
    check_bit("soft_reset", soft_reset, 1'b0);
    check_bit("irq_n", irq_n, 1'b1);

    read_identity();
    exercise_scratch();
    pulse_soft_reset();
    exercise_interrupts();
    probe_unmapped();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  task automatic read_identity();
    logic [0:31] data;
    logic [0:31] exp;
    opb_read(SYS_ID, data);
    check_word("sys id", data, 32'h0A55_0002);
    opb_read(SYS_REV, data);
    check_word("sys rev", data, 32'h0007_1234);
    exp     = '0;
    exp[15] = 1'b1; // Up-to-date flag set, soft reset idle.
    opb_read(SYS_CTRL, data);
    check_word("sys ctrl", data, exp);
  endtask

  task automatic exercise_scratch();
    logic [0:31] data;
    logic [0:31] model;
    logic [0:31] wdata;
    logic [0:3]  be;
    opb_read(SYS_SCRATCH, data);
    check_word("scratch reset", data, 32'hB00B_EEE5);
    model = 32'hB00B_EEE5;
    for (int n = 0; n < SCRATCH_WRITES; n++) begin
      wdata = $urandom;
      be    = 4'($urandom);
      opb_write(SYS_SCRATCH, be, wdata);
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          model[8*i +: 8] = wdata[8*i +: 8]; // Lane 0 is the top byte.
        end
      end
      opb_read(SYS_SCRATCH, data);
      check_word("scratch", data, model);
    end
  endtask

  task automatic pulse_soft_reset();
    logic [0:31] wdata;
    wdata     = '0;
    wdata[31] = 1'b1;
    opb_write(SYS_CTRL, 4'b0001, wdata);
    check_bit("soft_reset in ack", soft_reset_at_ack, 1'b1);
    check_bit("soft_reset after ack", soft_reset, 1'b0);
    opb_write(SYS_CTRL, 4'b1110, 32'hFFFF_FFFF); // Lane 3 off, no pulse.
    check_bit("soft_reset in ack", soft_reset_at_ack, 1'b0);
    check_bit("soft_reset after ack", soft_reset, 1'b0);
  endtask

  task automatic exercise_interrupts();
    logic [15:0] lines;
    logic [15:0] en;
    logic [0:31] data;
    logic [0:31] exp;
    int          waited;
    for (int r = 0; r < IRQ_ROUNDS; r++) begin
      opb_write(IRQ_ENABLE, 4'b0011, 32'h0);
      lines = 16'($urandom);
      if (lines == 16'h0) begin
        lines = 16'h0001;
      end
      app_irq = lines;
      repeat (2) @(negedge OPB_Clk);
      app_irq = '0;
      @(negedge OPB_Clk);
      exp        = '0;
      exp[16:31] = lines; // Line 0 at bit 31.
      opb_read(IRQ_STATUS, data);
      check_word("irq status", data, exp);
      check_bit("irq_n", irq_n, 1'b1);

      // Lowest pulsed line stays enabled so the output gets exercised.
      en = 16'($urandom) | (lines & (~lines + 16'h1));
      opb_write(IRQ_ENABLE, 4'b0011, {16'h0, en});
      exp        = '0;
      exp[16:31] = lines & en;
      opb_read(IRQ_PENDING, data);
      check_word("irq pending", data, exp);
      check_bit("irq_n", irq_n, ~|(lines & en));

      opb_write(IRQ_STATUS, 4'b0011, 32'h0000_FFFF);
      waited = 0;
      while (irq_n !== 1'b1 && waited < 2) begin
        @(negedge OPB_Clk);
        waited++;
      end
      check_bit("irq_n after clear", irq_n, 1'b1);
      opb_read(IRQ_STATUS, data);
      check_word("irq status after clear", data, 32'h0);
    end
  endtask

  task automatic probe_unmapped();
    req        = '0;
    req.abus   = UNMAPPED;
    req.be     = 4'hF;
    req.rnw    = 1'b1;
    req.select = 1'b1;
    repeat (8) begin
      @(negedge OPB_Clk);
      check_bit("xfer_ack", rsp.xfer_ack, 1'b0);
      check_bit("err_ack", rsp.err_ack, 1'b0);
      check_bit("retry", rsp.retry, 1'b0);
      check_bit("tout_sup", rsp.tout_sup, 1'b0);
      check_word("dbus", rsp.dbus, '0);
    end
    req = '0;
    @(negedge OPB_Clk);
  endtask

  `include "tb_checks.svh"

endmodule

`default_nettype wire
